// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_fetch_frontend
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/fetch_bus_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

// types that describe the memory side of the fetch front end
package fetch_bus_pkg;

	// one fetch address, the low two bits are always zero on the bus
	typedef logic [`FETCH_ADDR_W-1:0] addr_t;

	// one data word as returned by the memory
	typedef logic [31:0] bus_word_t;

	// count of fetches in flight or still to be discarded after a jump
	// sized so that the limit itself fits
	typedef logic [$clog2(`FETCH_MAX_PENDING + 1)-1:0] pending_t;

	// source of the address phase in the current cycle, in priority order
	// req_hold keeps an address that the bus has not yet accepted
	// req_jump presents the aligned jump target
	// req_seq presents the next sequential fetch address
	// req_idle leaves the address phase empty
	typedef enum logic [1:0] {
		req_hold,
		req_jump,
		req_seq,
		req_idle
	} req_kind_e;

endpackage

`default_nettype wire

// File: hw/fetch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_frontend (
	input  wire                             clk,
	input  wire                             rst_n,
	// fetch bus, address phase
	output fetch_bus_pkg::addr_t            mem_addr,
	output logic                            mem_addr_vld,
	input  wire                             mem_addr_rdy,
	// fetch bus, data phase, no back-pressure
	input  wire fetch_bus_pkg::bus_word_t   mem_data,
	input  wire                             mem_data_err,
	input  wire                             mem_data_vld,
	// jump request from the core
	input  wire fetch_bus_pkg::addr_t       jump_target,
	input  wire                             jump_target_vld,
	output logic                            jump_target_rdy,
	// decode side
	output instr_pkg::instr_t               cir,
	output logic                            cir_vld,
	output logic                            cir_err,
	input  wire                             cir_use
);

	// control from the fetch request logic
	logic               flush;
	logic               resp_vld;
	// queue head towards the CIR
	instr_pkg::instr_t  head_data;
	logic               head_err;
	logic               head_vld;
	logic               head_take;
	// queue occupancy back to the fetch request logic
	logic               queue_full;
	logic               queue_almost_full;

	// ----------------------------------------------------------------------
	// producer, bus requests and response filtering

	fetch_request u_fetch_request (
		.clk               (clk),
		.rst_n             (rst_n),
		.mem_addr          (mem_addr),
		.mem_addr_vld      (mem_addr_vld),
		.mem_addr_rdy      (mem_addr_rdy),
		.mem_data_vld      (mem_data_vld),
		.jump_target       (jump_target),
		.jump_target_vld   (jump_target_vld),
		.jump_target_rdy   (jump_target_rdy),
		.resp_vld          (resp_vld),
		.flush             (flush),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full)
	);

	// ----------------------------------------------------------------------
	// buffer, prefetch queue with bypass

	prefetch_queue u_prefetch_queue (
		.clk               (clk),
		.rst_n             (rst_n),
		.flush             (flush),
		.resp_vld          (resp_vld),
		.mem_data          (mem_data),
		.mem_data_err      (mem_data_err),
		.head_data         (head_data),
		.head_err          (head_err),
		.head_vld          (head_vld),
		.head_take         (head_take),
		.queue_full        (queue_full),
		.queue_almost_full (queue_almost_full)
	);

	// ----------------------------------------------------------------------
	// consumer, current instruction register

	instr_assembly u_instr_assembly (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.head_data (head_data),
		.head_err  (head_err),
		.head_vld  (head_vld),
		.head_take (head_take),
		.cir       (cir),
		.cir_vld   (cir_vld),
		.cir_err   (cir_err),
		.cir_use   (cir_use)
	);

endmodule

`default_nettype wire

// File: hw/fetch_request.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module fetch_request (
	input  wire                         clk,
	input  wire                         rst_n,
	// address phase of the fetch bus
	output fetch_bus_pkg::addr_t        mem_addr,
	output logic                        mem_addr_vld,
	input  wire                         mem_addr_rdy,
	// data phase strobe, only used here for tracking
	input  wire                         mem_data_vld,
	// jump request from the core
	input  wire fetch_bus_pkg::addr_t   jump_target,
	input  wire                         jump_target_vld,
	output logic                        jump_target_rdy,
	// filtered response strobe and flush pulse towards queue and CIR
	output logic                        resp_vld,
	output logic                        flush,
	// occupancy feedback from the prefetch queue
	input  wire                         queue_full,
	input  wire                         queue_almost_full
);

	fetch_bus_pkg::addr_t      fetch_addr;
	fetch_bus_pkg::addr_t      jump_addr;
	fetch_bus_pkg::req_kind_e  req_kind;
	fetch_bus_pkg::pending_t   pending_fetches;
	fetch_bus_pkg::pending_t   flush_pending;
	logic                      mem_addr_hold;
	logic                      jump_now;
	logic                      aph_accept;
	logic                      pending_full;
	logic                      fetch_stall;

	// ----------------------------------------------------------------------
	// jump acceptance

	// a held address phase must not change, so jumps wait for the bus
	assign jump_target_rdy = !mem_addr_hold;
	assign jump_now        = jump_target_vld && jump_target_rdy;

	// the queue and the CIR are emptied on the same edge that takes the jump
	assign flush = jump_now;

	// fetches are always whole words
	assign jump_addr = {jump_target[`FETCH_ADDR_W-1:2], 2'b00};

	// ----------------------------------------------------------------------
	// address phase request

	assign pending_full = pending_fetches >= fetch_bus_pkg::pending_t'(`FETCH_MAX_PENDING);

	// stall uses only registered counts, so no path runs from the bus
	// handshake back into the address phase
	assign fetch_stall = queue_full
		|| (queue_almost_full && pending_fetches != '0)
		|| pending_full;

	always_comb begin
		if (mem_addr_hold) begin
			req_kind = fetch_bus_pkg::req_hold;
		end else if (jump_target_vld && !pending_full) begin
			// a jump ignores the queue level since the queue is flushed anyway
			// it still waits while the bus limit is reached
			req_kind = fetch_bus_pkg::req_jump;
		end else if (!fetch_stall) begin
			req_kind = fetch_bus_pkg::req_seq;
		end else begin
			req_kind = fetch_bus_pkg::req_idle;
		end
	end

	always_comb begin
		case (req_kind)
			fetch_bus_pkg::req_jump: mem_addr = jump_addr;
			default:                 mem_addr = fetch_addr;
		endcase
		mem_addr_vld = req_kind != fetch_bus_pkg::req_idle;
	end

	assign aph_accept = mem_addr_vld && mem_addr_rdy;

	// fetch address runs one word ahead of whatever was last accepted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= `FETCH_RESET_VECTOR;
		end else if (jump_now) begin
			// a jump accepted by the bus straight away is already fetched
			if (aph_accept) begin
				fetch_addr <= jump_addr + fetch_bus_pkg::addr_t'(4);
			end else begin
				fetch_addr <= jump_addr;
			end
		end else if (aph_accept) begin
			fetch_addr <= fetch_addr + fetch_bus_pkg::addr_t'(4);
		end
	end

	// ----------------------------------------------------------------------
	// bus pipeline tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_addr_hold   <= 1'b0;
			pending_fetches <= '0;
			flush_pending   <= '0;
		end else begin
			mem_addr_hold   <= mem_addr_vld && !mem_addr_rdy;
			pending_fetches <= pending_fetches
				+ fetch_bus_pkg::pending_t'(aph_accept)
				- fetch_bus_pkg::pending_t'(mem_data_vld);
			// everything still outstanding at the jump belongs to the old path
			if (jump_now) begin
				flush_pending <= pending_fetches - fetch_bus_pkg::pending_t'(mem_data_vld);
			end else if (flush_pending != '0 && mem_data_vld) begin
				flush_pending <= flush_pending - fetch_bus_pkg::pending_t'(1);
			end
		end
	end

	// responses to fetches from before a jump are dropped here
	assign resp_vld = mem_data_vld && flush_pending == '0;

endmodule

`default_nettype wire

// File: hw/instr_assembly.sv
`timescale 1ns/1ns
`default_nettype none

module instr_assembly (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      flush,
	// head of the prefetch queue, or the bus word when it is bypassed
	input  wire instr_pkg::instr_t   head_data,
	input  wire                      head_err,
	input  wire                      head_vld,
	output logic                     head_take,
	// current instruction register as seen by decode
	output instr_pkg::instr_t        cir,
	output logic                     cir_vld,
	output logic                     cir_err,
	input  wire                      cir_use
);

	// ----------------------------------------------------------------------
	// refill condition

	// the CIR takes a new word when it is empty, or when decode
	// consumes the current one in this same cycle
	// cir_use is only raised while cir_vld is high
	assign head_take = head_vld && (!cir_vld || cir_use);

	// ----------------------------------------------------------------------
	// CIR state

	// a flush wins over a refill, the word offered in the jump cycle
	// belongs to the old path
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cir_vld <= 1'b0;
			cir_err <= 1'b0;
		end else if (flush) begin
			cir_vld <= 1'b0;
			cir_err <= 1'b0;
		end else if (head_take) begin
			cir_vld <= 1'b1;
			// a bus error travels with its word and only shows up here,
			// where decode can raise the exception
			cir_err <= head_err;
		end else if (cir_use) begin
			// consumed with nothing to replace it
			cir_vld <= 1'b0;
			cir_err <= 1'b0;
		end
	end

	// instruction word itself, only meaningful while cir_vld is set
	always_ff @(posedge clk) begin
		if (head_take) begin
			cir <= head_data;
		end
	end

endmodule

`default_nettype wire

// File: hw/instr_pkg.sv
`default_nettype none

`include "fetch_cfg.svh"

// types that describe the instruction side of the fetch front end
package instr_pkg;

	// one 32-bit instruction word
	// compressed instructions are not supported, so a fetched word is
	// always exactly one instruction
	typedef logic [31:0] instr_t;

	// occupancy of the prefetch queue, counting 0 up to the full depth
	typedef logic [$clog2(`FETCH_QUEUE_DEPTH + 1)-1:0] queue_level_t;

endpackage

`default_nettype wire

// File: hw/prefetch_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module prefetch_queue (
	input  wire                             clk,
	input  wire                             rst_n,
	input  wire                             flush,
	// filtered bus response
	input  wire                             resp_vld,
	input  wire fetch_bus_pkg::bus_word_t   mem_data,
	input  wire                             mem_data_err,
	// head of queue towards the CIR
	output instr_pkg::instr_t               head_data,
	output logic                            head_err,
	output logic                            head_vld,
	input  wire                             head_take,
	// occupancy towards the fetch request logic
	output logic                            queue_full,
	output logic                            queue_almost_full
);

	localparam int DEPTH = `FETCH_QUEUE_DEPTH;

	// entry 0 is always the oldest word, validity is kept compact
	instr_pkg::instr_t        q_data [0:DEPTH-1];
	logic                     q_err  [0:DEPTH-1];
	logic                     q_vld  [0:DEPTH-1];
	// same entries with the incoming bus word in each free slot and above the top
	instr_pkg::instr_t        ext_data [0:DEPTH];
	logic                     ext_err  [0:DEPTH];
	logic                     ext_vld  [0:DEPTH];
	// validity of the entry below, entry 0 sees a permanent 1
	logic                     below_vld [0:DEPTH-1];
	instr_pkg::queue_level_t  level;
	logic                     q_empty;
	logic                     push;
	logic                     pop;

	always_comb begin
		level = '0;
		for (int i = 0; i < DEPTH; i++) begin
			ext_data[i] = q_vld[i] ? q_data[i] : mem_data;
			ext_err[i]  = q_vld[i] ? q_err[i] : mem_data_err;
			ext_vld[i]  = q_vld[i];
			if (q_vld[i]) begin
				level = level + instr_pkg::queue_level_t'(1);
			end
		end
		ext_data[DEPTH] = mem_data;
		ext_err[DEPTH]  = mem_data_err;
		ext_vld[DEPTH]  = 1'b0;
		below_vld[0] = 1'b1;
		for (int i = 1; i < DEPTH; i++) begin
			below_vld[i] = q_vld[i-1];
		end
	end

	assign q_empty           = !q_vld[0];
	assign queue_full        = level == instr_pkg::queue_level_t'(DEPTH);
	assign queue_almost_full = level >= instr_pkg::queue_level_t'(DEPTH - 1);

	// ----------------------------------------------------------------------
	// head and bypass

	// with nothing buffered, bus data goes straight on to the CIR
	assign head_vld  = q_vld[0] || resp_vld;
	assign head_data = q_empty ? mem_data : q_data[0];
	assign head_err  = q_empty ? mem_data_err : q_err[0];

	assign pop  = head_take && !q_empty;
	// a response taken through the bypass is not written as well
	assign push = resp_vld && !(head_take && q_empty);

	// ----------------------------------------------------------------------
	// shifting storage

	// on a pop every entry moves down one, the free slot takes the new word
	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (pop || (push && !q_vld[i])) begin
				q_data[i] <= ext_data[i+1];
				q_err[i]  <= ext_err[i+1];
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				q_vld[i] <= 1'b0;
			end
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (flush) begin
					q_vld[i] <= 1'b0;
				end else if (ext_vld[i+1] && pop) begin
					q_vld[i] <= 1'b1;
				end else if (q_vld[i] && pop) begin
					// the top entry refills only when a word arrives together
					q_vld[i] <= push;
				end else if (!q_vld[i]) begin
					q_vld[i] <= push && !pop && below_vld[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: include/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// sizing of the instruction fetch front end

// width of a fetch address, the bus carries word-aligned addresses only
`define FETCH_ADDR_W 32

// number of prefetch queue entries
// two is the smallest depth that keeps full throughput while decode stalls
`define FETCH_QUEUE_DEPTH 2

// upper bound on bus fetches in flight at any time
`define FETCH_MAX_PENDING 2

// address of the first fetch after reset
`define FETCH_RESET_VECTOR 32'h0000_0040

`endif

// File: project.f
+incdir+include
hw/fetch_bus_pkg.sv
hw/instr_pkg.sv
hw/fetch_request.sv
hw/prefetch_queue.sv
hw/instr_assembly.sv
hw/fetch_frontend.sv
verif/tb_fetch_frontend.sv

// File: verif/tb_fetch_frontend.sv
`timescale 1ns/1ns
`default_nettype none

`include "fetch_cfg.svh"

module tb_fetch_frontend;

	// one test per row, jump first when asked, then a decode hold, then consumption
	typedef struct packed {
		logic        do_jump;
		logic [31:0] target;
		logic [31:0] err_addr;
		logic [7:0]  rdy_pat;
		logic [7:0]  use_pat;
		logic [7:0]  hold_cycles;
		logic [7:0]  n_instr;
	} test_row_t;

	localparam int N_TESTS = 6;
	localparam int JUMP_TIMEOUT = 64;
	localparam int CONSUME_TIMEOUT = 800;
	localparam logic [31:0] DATA_XOR = 32'hA5A5_0000;

	logic                      clk = 1'b0;
	logic                      rst_n;
	fetch_bus_pkg::addr_t      mem_addr;
	logic                      mem_addr_vld;
	logic                      mem_addr_rdy = 1'b0;
	fetch_bus_pkg::bus_word_t  mem_data = '0;
	logic                      mem_data_err = 1'b0;
	logic                      mem_data_vld = 1'b0;
	fetch_bus_pkg::addr_t      jump_target;
	logic                      jump_target_vld;
	logic                      jump_target_rdy;
	instr_pkg::instr_t         cir;
	logic                      cir_vld;
	logic                      cir_err;
	logic                      cir_use;

	test_row_t                 tbl [0:N_TESTS-1];
	integer                    seed = 9;
	// memory model settings for the running test
	logic [7:0]                rdy_pat = 8'hFF;
	fetch_bus_pkg::addr_t      err_addr = '0;
	logic [2:0]                use_idx = '0;
	fetch_bus_pkg::addr_t      addr_q [$];
	int                        due_q [$];
	int                        cycle;
	// bus monitor state
	int                        in_flight;
	logic                      was_held;
	fetch_bus_pkg::addr_t      held_addr;
	// scoreboard, next address expected in the CIR
	fetch_bus_pkg::addr_t      exp_addr;
	fetch_bus_pkg::addr_t      row_err;
	int                        checks;
	int                        errors;
	int                        tests_run;
	logic                      timed_out;

	fetch_frontend dut0 (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_err         (cir_err),
		.cir_use         (cir_use)
	);

	initial begin
		forever #50 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// memory model

	// in-order responses after 1 to 3 cycles, the word is its address XOR a constant
	// the same random draw also picks the mem_addr_rdy and cir_use pattern bits
	always @(posedge clk) begin : memory_model
		logic [31:0]           rnd;
		fetch_bus_pkg::addr_t  addr;
		rnd = $random(seed);
		mem_addr_rdy <= rdy_pat[rnd[2:0]];
		use_idx <= rnd[5:3];
		mem_data_vld <= 1'b0;
		if (!rst_n) begin
			addr_q.delete();
			due_q.delete();
			cycle = 0;
		end else begin
			cycle = cycle + 1;
			if (due_q.size() != 0 && due_q[0] <= cycle) begin
				addr = addr_q.pop_front();
				void'(due_q.pop_front());
				mem_data <= addr ^ DATA_XOR;
				mem_data_err <= addr == err_addr;
				mem_data_vld <= 1'b1;
			end
			if (mem_addr_vld && mem_addr_rdy) begin
				addr_q.push_back(mem_addr);
				due_q.push_back(cycle + 1 + int'(rnd[9:8]) % 3);
			end
		end
	end

	// ----------------------------------------------------------------------
	// checking

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp) begin
			errors = errors + 1;
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	// every wait after reset goes through here, so the bus is watched each cycle
	task automatic tick();
		@(posedge clk);
		// an address the bus refused last cycle is still offered, unchanged
		if (was_held) begin
			check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd1);
			check_value("mem_addr", mem_addr, held_addr);
			check_value("jump_target_rdy", 32'(jump_target_rdy), 32'd0);
		end
		in_flight = in_flight + int'(mem_addr_vld && mem_addr_rdy) - int'(mem_data_vld);
		if (in_flight > `FETCH_MAX_PENDING) begin
			$display("More than %0d fetches are in flight on the bus", `FETCH_MAX_PENDING);
			errors = errors + 1;
		end
		was_held = mem_addr_vld && !mem_addr_rdy;
		held_addr = mem_addr;
	endtask

	task automatic take_jump(input fetch_bus_pkg::addr_t target);
		int waited;
		waited = 0;
		jump_target <= target;
		jump_target_vld <= 1'b1;
		do begin
			tick();
			waited++;
		end while (!(jump_target_vld && jump_target_rdy) && waited < JUMP_TIMEOUT);
		jump_target_vld <= 1'b0;
		if (jump_target_vld && jump_target_rdy) begin
			// the first word after the jump comes from the word-aligned target
			exp_addr = target & ~32'h3;
		end else begin
			$display("Jump to 0x%08h was not accepted in time", target);
			timed_out = 1'b1;
		end
	endtask

	// decode stalls, the CIR must not move while it waits
	task automatic hold_decode(input int cycles);
		instr_pkg::instr_t held;
		logic              seen;
		seen = 1'b0;
		held = '0;
		repeat (cycles) begin
			tick();
			if (cir_vld) begin
				if (seen) begin
					check_value("cir", cir, held);
				end
				held = cir;
				seen = 1'b1;
			end
		end
	endtask

	task automatic consume(input int n, input logic [7:0] pat);
		int got;
		int waited;
		got = 0;
		waited = 0;
		while (got < n && waited < CONSUME_TIMEOUT) begin
			tick();
			waited++;
			// consumption happens at an edge with both cir_vld and cir_use high
			if (cir_vld && cir_use) begin
				check_value("cir", cir, exp_addr ^ DATA_XOR);
				check_value("cir_err", 32'(cir_err), 32'(exp_addr == row_err));
				exp_addr = exp_addr + 32'd4;
				got++;
			end
			cir_use <= got < n && pat[use_idx];
		end
		if (got < n) begin
			$display("Only %0d of %0d instructions reached decode in time", got, n);
			timed_out = 1'b1;
		end
	endtask

	task automatic run_test(input int t);
		test_row_t row;
		row = tbl[t];
		rdy_pat <= row.rdy_pat;
		err_addr <= row.err_addr;
		row_err = row.err_addr;
		if (row.do_jump) begin
			take_jump(row.target);
		end
		if (!timed_out) begin
			hold_decode(int'(row.hold_cycles));
			consume(int'(row.n_instr), row.use_pat);
		end
		tests_run = tests_run + 1;
		$display("test %0d finished, next address 0x%08h, errors so far %0d",
			t, exp_addr, errors);
	endtask

	// ----------------------------------------------------------------------
	// stimulus

	initial begin
		rst_n = 1'b0;
		jump_target = '0;
		jump_target_vld = 1'b0;
		cir_use = 1'b0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		timed_out = 1'b0;
		in_flight = 0;
		was_held = 1'b0;
		held_addr = '0;
		// jump, target, error address, rdy pattern, use pattern, hold, count
		tbl[0] = '{1'b0, 32'h0000_0000, 32'h0000_0048, 8'hFF, 8'hFF, 8'd0, 8'd8};
		tbl[1] = '{1'b1, 32'h0000_1000, 32'hFFFF_FFF0, 8'h5A, 8'hB7, 8'd0, 8'd12};
		tbl[2] = '{1'b1, 32'h0000_2002, 32'h0000_2008, 8'hEE, 8'hFF, 8'd20, 8'd10};
		// the error word 0x3010 is prefetched here and flushed by the next jump
		tbl[3] = '{1'b1, 32'h0000_3000, 32'h0000_3010, 8'hFF, 8'hFF, 8'd0, 8'd4};
		tbl[4] = '{1'b1, 32'h0000_3800, 32'h0000_380C, 8'h77, 8'h6D, 8'd6, 8'd16};
		tbl[5] = '{1'b1, 32'h0000_0044, 32'h0000_0048, 8'h13, 8'hFF, 8'd4, 8'd6};
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		tick();
		// first address phase after reset
		check_value("mem_addr_vld", 32'(mem_addr_vld), 32'd1);
		check_value("mem_addr", mem_addr, `FETCH_RESET_VECTOR);
		check_value("jump_target_rdy", 32'(jump_target_rdy), 32'd1);
		check_value("cir_vld", 32'(cir_vld), 32'd0);
		exp_addr = `FETCH_RESET_VECTOR;
		for (int t = 0; t < N_TESTS && !timed_out; t++) begin
			run_test(t);
		end
		$display("%0d of %0d tests run, %0d checks, %0d errors",
			tests_run, N_TESTS, checks, errors);
		if (errors == 0 && !timed_out) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
